// ==== logic/fetch_cfg.svh ====
/*
  Configuration macros for the compressed-instruction fetch front end.
  Opcode and function code values must match the 48-bit internal format
  used by decode. RESET_PC must fit in PC_W bits and be parcel aligned.
  COMPRESSED_TAG is compared against bits 7:6 of a first parcel.
*/
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ====================
// Fetch addressing
// ====================
`define PC_W            32
`define RESET_PC        32'h0000_1000

// ====================
// Major opcodes, bits 5:0
// ====================
`define OP_BRK          6'h00
`define OP_R2           6'h02     // Register to register group
`define OP_ADDI         6'h04
`define OP_ANDI         6'h08
`define OP_ORI          6'h09
`define OP_LX           6'h16     // Load, size in low immediate bits
`define OP_JAL          6'h18
`define OP_NOP          6'h1C
`define OP_RET          6'h29
`define OP_SX           6'h36     // Store, size in low immediate bits
`define OP_BCC          6'h38     // Condition in bits 20:18

// R2 function codes, bits 31:26
`define FN_ADD          6'h04
`define FN_SUB          6'h05
`define FN_AND          6'h08
`define FN_OR           6'h09
`define FN_XOR          6'h0A
`define FN_SHIFT        6'h0F     // Shift by immediate 0-31
`define FN_MOV          6'h22

`define CLASS_CODE      2'b10
`define COMPRESSED_TAG  2'b01

`endif

// ==== logic/fetchPkg.sv ====
/*
  Shared types for the fetch front end.
  The PC width comes from the configuration header.
  mapReg covers only the eight registers reachable from a 3-bit field.
*/
`include "fetch_cfg.svh"

package fetchPkg;

	typedef logic [15:0]        parcelT;
	typedef logic [47:0]        instr48T;
	typedef logic [`PC_W-1:0]   pcT;
	typedef logic [4:0]         regT;

	// Aligner to expander stage
	typedef struct packed {
		pcT          pc;
		logic [31:0] raw;            // Low parcel in bits 15:0
		logic        isCompressed;
	} alignedT;

	// Expander to output stage
	typedef struct packed {
		pcT      pc;
		instr48T instr;
	} expandedT;

	// Compressed register field onto the architectural register file
	function automatic regT mapReg(input logic [2:0] rg);
		case (rg)
			3'd0:    mapReg = 5'd1;      // Return value
			3'd1:    mapReg = 5'd3;
			3'd2:    mapReg = 5'd4;      // Temporaries
			3'd3:    mapReg = 5'd11;
			3'd4:    mapReg = 5'd12;     // Register variables
			3'd5:    mapReg = 5'd18;
			3'd6:    mapReg = 5'd19;
			default: mapReg = 5'd20;     // Arguments
		endcase
	endfunction

endpackage

// ==== logic/parcelAligner.sv ====
/*
  Groups 16-bit parcels into one- or two-parcel instructions.
  A first parcel with COMPRESSED_TAG in bits 7:6 is a whole instruction.
  Any other first parcel is held until the high parcel arrives.
  Output is combinational from the parcel input. No flush or redirect.
*/
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module parcelAligner
(
	input  logic             clk,
	input  logic             rstN,
	input  fetchPkg::parcelT parcel,
	input  logic             parcelValid,
	output logic             parcelReady,
	output logic             alignedValid,
	output fetchPkg::pcT     alignedPc,
	output logic [31:0]      alignedInstr,
	output logic             alignedCompressed,
	input  logic             alignedReady
);

	logic             halfFlag;       // Low parcel of a full instruction held
	fetchPkg::parcelT lowParcel;
	fetchPkg::pcT     pc;
	logic             tagCompressed;
	logic             completing;     // This parcel ends an instruction
	logic             accept;

	assign tagCompressed = (parcel[7:6] == `COMPRESSED_TAG);
	assign completing    = halfFlag || tagCompressed;

	// ====================
	// Output side
	// ====================
	assign alignedValid      = parcelValid && completing;
	assign alignedPc         = pc;
	assign alignedCompressed = !halfFlag;
	assign alignedInstr      = halfFlag ? {parcel, lowParcel} : {16'h0000, parcel};

	// Storing a low parcel needs no room downstream
	assign parcelReady = completing ? alignedReady : 1'b1;
	assign accept      = parcelValid && parcelReady;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			halfFlag <= 1'b0;
			pc       <= `RESET_PC;
		end
		else if (accept)
		begin
			if (!completing)
				halfFlag <= 1'b1;
			else
			begin
				halfFlag <= 1'b0;
				pc       <= pc + (halfFlag ? fetchPkg::pcT'(4) : fetchPkg::pcT'(2));
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept && !halfFlag)
			lowParcel <= parcel;          // Only kept when not completing
	end

endmodule

// ==== logic/pipeSlice.sv ====
/*
  Single-entry valid/ready register stage with full throughput.
  inReady depends combinationally on outReady.
  A held entry is never overwritten before it is taken.
*/
`timescale 1ns/1ps

module pipeSlice
#(
	parameter type payloadT = logic [7:0]
)
(
	input  logic    clk,
	input  logic    rstN,
	input  logic    inValid,
	output logic    inReady,
	input  payloadT inData,
	output logic    outValid,
	input  logic    outReady,
	output payloadT outData
);

	logic    full;
	payloadT dataReg;

	assign inReady  = !full || outReady;  // Empty, or draining this cycle
	assign outValid = full;
	assign outData  = dataReg;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			full <= 1'b0;
		else if (inValid && inReady)
			full <= 1'b1;
		else if (outReady)
			full <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (inValid && inReady)
			dataReg <= inData;
	end

endmodule

// ==== logic/instrExpander.sv ====
/*
  Expands a compressed instruction into the 48-bit internal format.
  Full instructions pass through zero-extended to 48 bits.
  Decode uses bits 15:12 and bit 6 of the low parcel.
  Unassigned codes become a NOP with all fields zero.
*/
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module instrExpander
(
	input  logic [31:0]       rawInstr,
	input  logic              isCompressed,
	output fetchPkg::instr48T expanded
);

	logic [15:0]   c;
	logic [4:0]    imm5;             // Common split immediate
	logic [13:0]   fieldHi;          // Bits 31:18
	fetchPkg::regT rt;               // Bits 17:13
	fetchPkg::regT ra;               // Bits 12:8
	logic [5:0]    op;
	logic [5:0]    aluFn;

	assign c    = rawInstr[15:0];
	assign imm5 = {c[11:8], c[5]};

	// Function for the mapped-register R2 group
	always_comb
	begin
		case (c[11:10])
			2'd0:    aluFn = `FN_SUB;
			2'd1:    aluFn = `FN_AND;
			2'd2:    aluFn = `FN_OR;
			default: aluFn = `FN_XOR;
		endcase
	end

	always_comb
	begin
		fieldHi = '0;
		rt      = '0;
		ra      = '0;
		op      = `OP_NOP;
		casez ({c[15:12], c[6]})
			5'b00000:
			begin
				rt = c[4:0];
				ra = c[4:0];
				op = `OP_ADDI;
				if (c[4:0] == 5'd31)
					fieldHi = {{6{c[11]}}, imm5, 3'b000};  // SP adjust in doublewords
				else
					fieldHi = {{9{c[11]}}, imm5};
			end
			5'b00010:
			begin
				if (c[4:0] == 5'd0)
				begin
					fieldHi = {8'd0, 4'd1, 2'd0};          // BRK cause class
					rt      = 5'd1;
					ra      = imm5;
					op      = `OP_BRK;
				end
				else
				begin
					fieldHi = {{9{c[11]}}, imm5};          // LDI as ORI from r0
					rt      = c[4:0];
					op      = `OP_ORI;
				end
			end
			5'b00100:
			begin
				if (c[4:0] == 5'd0)
				begin
					fieldHi = {6'd0, imm5, 3'd0};          // Stack release
					rt      = 5'd29;
					ra      = 5'd31;
					op      = `OP_RET;
				end
				else
				begin
					fieldHi = {{9{c[11]}}, imm5};
					rt      = c[4:0];
					ra      = c[4:0];
					op      = `OP_ANDI;
				end
			end
			5'b00110:
			begin
				fieldHi = {`FN_SHIFT, 3'd0, imm5};        // SHLI
				rt      = c[4:0];
				ra      = c[4:0];
				op      = `OP_R2;
			end
			5'b01000:
			begin
				rt = fetchPkg::mapReg(c[2:0]);
				ra = fetchPkg::mapReg(c[2:0]);
				op = `OP_R2;
				case (c[5:4])
					2'd0: fieldHi = {`FN_SHIFT, 3'd1, c[11:8], c[3]};   // SHRI
					2'd1: fieldHi = {`FN_SHIFT, 3'd3, c[11:8], c[3]};   // ASRI
					2'd2:
					begin
						fieldHi = {{9{c[11]}}, c[11:8], c[3]};
						op      = `OP_ORI;
					end
					default: fieldHi = {aluFn, 3'b011, fetchPkg::mapReg({c[9:8], c[3]})};
				endcase
			end
			5'b01110:
			begin
				fieldHi = {c[11], c[11:8], c[5:0], 3'd0}; // BRA as r0 == r0
				op      = `OP_BCC;
			end
			5'b10??0, 5'b11??0:
			begin
				fieldHi = {{6{c[11]}}, imm5, 2'b00, c[14]};  // BEQZ or BNEZ
				ra      = c[4:0];
				op      = `OP_BCC;
			end
			5'b00001:
			begin
				fieldHi = {`FN_MOV, 3'd7, 5'd0};
				rt      = imm5;
				ra      = c[4:0];
				op      = `OP_R2;
			end
			5'b00011:
			begin
				fieldHi = {`FN_ADD, 3'b011, c[4:0]};      // Word size at 25:23
				rt      = imm5;
				ra      = c[4:0];
				op      = `OP_R2;
			end
			5'b00101:
			begin
				rt = imm5;                                 // JALR link register
				ra = c[4:0];
				op = `OP_JAL;
			end
			5'b01??1, 5'b10??1, 5'b11??1:
			begin
				// c[12] picks word over half, c[13] picks FP over SP
				op = (c[15:14] == 2'b10 || c[15:13] == 3'b111) ? `OP_SX : `OP_LX;
				if (c[15:14] == 2'b11)
				begin
					rt      = fetchPkg::mapReg({c[9:8], c[5]});
					ra      = fetchPkg::mapReg(c[2:0]);
					fieldHi = c[12] ? {{7{c[11]}}, c[11:10], c[4:3], 3'd4}
					                : {{8{c[11]}}, c[11:10], c[4:3], 2'd2};
				end
				else
				begin
					rt      = c[4:0];
					ra      = c[13] ? 5'd30 : 5'd31;
					fieldHi = c[12] ? {{6{c[11]}}, imm5, 3'd4} : {{7{c[11]}}, imm5, 2'd2};
				end
			end
			default: op = `OP_NOP;
		endcase
	end

	assign expanded = isCompressed ? {16'h0000, fieldHi, rt, ra, `CLASS_CODE, op}
	                               : {16'h0000, rawInstr};

endmodule

// ==== logic/fetchExpandTop.sv ====
/*
  Fetch front end from parcel stream to 48-bit instructions.
  Two register slices give a latency of two cycles from the last parcel.
  No flush input. The upstream must restart the stream on a redirect.
*/
`timescale 1ns/1ps

module fetchExpandTop
(
	input  logic              clk,
	input  logic              rstN,
	input  fetchPkg::parcelT  parcel,
	input  logic              parcelValid,
	output logic              parcelReady,
	output logic              outValid,
	output fetchPkg::pcT      outPc,
	output fetchPkg::instr48T outInstr,
	input  logic              outReady
);

	logic               alignedValid;
	logic               alignedReady;
	fetchPkg::pcT       alignedPc;
	logic [31:0]        alignedInstr;
	logic               alignedCompressed;
	fetchPkg::alignedT  alignIn;
	fetchPkg::alignedT  alignOut;
	logic               alignOutValid;
	logic               alignOutReady;
	fetchPkg::instr48T  expandedWord;
	fetchPkg::expandedT expIn;
	fetchPkg::expandedT expOut;

	// ====================
	// Stage 1, alignment
	// ====================
	parcelAligner u_parcelAligner (
		.clk(clk), .rstN(rstN),
		.parcel(parcel), .parcelValid(parcelValid), .parcelReady(parcelReady),
		.alignedValid(alignedValid), .alignedPc(alignedPc), .alignedInstr(alignedInstr),
		.alignedCompressed(alignedCompressed), .alignedReady(alignedReady)
	);

	assign alignIn.pc           = alignedPc;
	assign alignIn.raw          = alignedInstr;
	assign alignIn.isCompressed = alignedCompressed;

	pipeSlice #(.payloadT(fetchPkg::alignedT)) u_alignSlice (
		.clk(clk), .rstN(rstN),
		.inValid(alignedValid), .inReady(alignedReady), .inData(alignIn),
		.outValid(alignOutValid), .outReady(alignOutReady), .outData(alignOut)
	);

	// ====================
	// Stage 2, expansion
	// ====================
	instrExpander u_instrExpander (
		.rawInstr(alignOut.raw), .isCompressed(alignOut.isCompressed),
		.expanded(expandedWord)
	);

	assign expIn.pc    = alignOut.pc;
	assign expIn.instr = expandedWord;

	pipeSlice #(.payloadT(fetchPkg::expandedT)) u_outSlice (
		.clk(clk), .rstN(rstN),
		.inValid(alignOutValid), .inReady(alignOutReady), .inData(expIn),
		.outValid(outValid), .outReady(outReady), .outData(expOut)
	);

	assign outPc    = expOut.pc;
	assign outInstr = expOut.instr;

endmodule

// ==== bench/expandChecker.sv ====
/*
  Compares each output transfer with the expected records in order.
  Expected records are the e lines of bench/expand_stim.txt.
  Also flags outValid before any parcel was accepted.
*/
`timescale 1ns/1ps

module expandChecker
(
	input  logic              clk,
	input  logic              rstN,
	input  logic              parcelValid,
	input  logic              parcelReady,
	input  logic              outValid,
	input  logic              outReady,
	input  fetchPkg::pcT      outPc,
	input  fetchPkg::instr48T outInstr,
	input  logic              endOfRun,
	output int                errorCount,
	output int                extraCount,
	output logic              allSeen
);

	string        names[$];
	logic [31:0]  expPc[$];
	logic [47:0]  expInstr[$];
	int           seen;
	logic         anyAccepted;
	logic         reported;

	initial
	begin
		int          fd;
		string       line;
		string       name;
		logic [31:0] pcVal;
		logic [47:0] instrVal;
		errorCount  = 0;
		extraCount  = 0;
		seen        = 0;
		anyAccepted = 1'b0;
		reported    = 1'b0;
		fd = $fopen("bench/expand_stim.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open bench/expand_stim.txt for expected records");
			errorCount = 1;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if ($sscanf(line, "e %s %h %h", name, pcVal, instrVal) == 3)
				begin
					names.push_back(name);
					expPc.push_back(pcVal);
					expInstr.push_back(instrVal);
				end
			end
			$fclose(fd);
		end
	end

	assign allSeen = (names.size() > 0) && (seen == names.size());

	always @(posedge clk)
	begin
		if (!rstN && outValid)
		begin
			$display("outValid was high during reset");
			errorCount <= errorCount + 1;
		end
		else if (rstN)
		begin
			if (outValid && !anyAccepted)
			begin
				$display("outValid rose before any parcel was supplied");
				errorCount <= errorCount + 1;
			end
			if (parcelValid && parcelReady)
				anyAccepted <= 1'b1;
			if (outValid && outReady)
			begin
				if (seen >= names.size())
				begin
					$display("Surplus output pc %h instr %h", outPc, outInstr);
					extraCount <= extraCount + 1;
				end
				else
				begin
					if (outPc !== expPc[seen] || outInstr !== expInstr[seen])
					begin
						$display("Fail %s: expected pc %h instr %h, actual pc %h instr %h",
							names[seen], expPc[seen], expInstr[seen], outPc, outInstr);
						errorCount <= errorCount + 1;
					end
					seen <= seen + 1;
				end
			end
		end
		// Records never seen count once as an error
		if (endOfRun && !reported)
		begin
			reported <= 1'b1;
			if (seen < names.size())
			begin
				for (int i = seen; i < names.size(); i++)
					$display("Missing output for record %s", names[i]);
				errorCount <= errorCount + 1;
			end
		end
	end

endmodule

// ==== bench/fetchExpandTb.sv ====
/*
  Testbench for the fetch front end.
  Parcels come from bench/expand_stim.txt, run from the project root.
  Input gaps and output stalls use a fixed-seed LFSR.
  Checking is done in expandChecker.
*/
`timescale 1ns/1ps

module fetchExpandTb;

	logic              clk;
	logic              rstN;
	fetchPkg::parcelT  parcel;
	logic              parcelValid;
	logic              parcelReady;
	logic              outValid;
	fetchPkg::pcT      outPc;
	fetchPkg::instr48T outInstr;
	logic              outReady;
	logic              endOfRun;
	logic              running;
	logic              allSeen;
	int                errorCount;
	int                extraCount;
	logic [15:0]       parcelMem[$];
	logic [15:0]       lfsrState;
	int                pIdx;
	int                cycles;
	int                cycleLimit;
	logic              timedOut;

	fetchExpandTop u_fetchExpandTop (
		.clk(clk), .rstN(rstN),
		.parcel(parcel), .parcelValid(parcelValid), .parcelReady(parcelReady),
		.outValid(outValid), .outPc(outPc), .outInstr(outInstr), .outReady(outReady)
	);

	expandChecker u_expandChecker (
		.clk(clk), .rstN(rstN),
		.parcelValid(parcelValid), .parcelReady(parcelReady),
		.outValid(outValid), .outReady(outReady), .outPc(outPc), .outInstr(outInstr),
		.endOfRun(endOfRun), .errorCount(errorCount), .extraCount(extraCount),
		.allSeen(allSeen)
	);

	// Galois LFSR, one step per bit taken
	function automatic logic lfsrBit();
		logic outBit;
		outBit    = lfsrState[0];
		lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
		return outBit;
	endfunction

	function automatic logic stallNow();
		logic a;
		logic b;
		a = lfsrBit();
		b = lfsrBit();
		return !a && !b;                  // About one cycle in four
	endfunction

	task automatic loadParcels();
		int    fd;
		string line;
		logic [15:0] value;
		fd = $fopen("bench/expand_stim.txt", "r");
		if (fd == 0)
			$display("Could not open the stimulus file bench/expand_stim.txt");
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if ($sscanf(line, "p %h", value) == 1)
					parcelMem.push_back(value);
			end
			$fclose(fd);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ====================
	// Parcel and stall driver
	// ====================
	always @(posedge clk)
	begin
		if (running)
		begin
			if (parcelValid && parcelReady)
				pIdx = pIdx + 1;
			if (!(parcelValid && !parcelReady))   // Hold until taken
			begin
				if (pIdx < parcelMem.size() && !stallNow())
				begin
					parcel      <= parcelMem[pIdx];
					parcelValid <= 1'b1;
				end
				else
					parcelValid <= 1'b0;
			end
			outReady <= !stallNow();
		end
	end

	initial
	begin
		rstN        = 1'b0;
		parcel      = '0;
		parcelValid = 1'b0;
		outReady    = 1'b1;
		endOfRun    = 1'b0;
		running     = 1'b0;
		lfsrState   = 16'd63372;
		pIdx        = 0;
		cycles      = 0;
		timedOut    = 1'b0;
		loadParcels();
		cycleLimit = parcelMem.size() * 8 + 200;
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		repeat (3) @(posedge clk);        // Idle window, outValid must stay low
		running <= 1'b1;
		while (!allSeen && !timedOut)
		begin
			@(posedge clk);
			cycles = cycles + 1;
			if (cycles >= cycleLimit)
				timedOut = 1'b1;
		end
		if (timedOut)
			$display("Timeout: not all expected outputs arrived within %0d cycles", cycleLimit);
		repeat (20) @(posedge clk);       // Catch surplus outputs
		endOfRun <= 1'b1;
		repeat (2) @(posedge clk);
		$display("Errors: %0d, extra outputs: %0d", errorCount, extraCount);
		if (errorCount == 0 && extraCount == 0 && !timedOut)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== tb.f ====
logic/fetchPkg.sv
logic/parcelAligner.sv
logic/pipeSlice.sv
logic/instrExpander.sv
logic/fetchExpandTop.sv
bench/expandChecker.sv
bench/fetchExpandTb.sv
+incdir+logic

// ==== run.sh ====
#!/bin/sh
# Builds and runs the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module fetchExpandTb \
	--Mdir obj_dir -o simv > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "Build failed with status $status"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== bench/expand_stim.txt ====
# p <parcel hex>: one parcel, in stream order
# e <test name> <pc hex> <48-bit instruction hex>: expected outputs in order
p 0365
e movC 00001000 00008B80E582
p 124A
e addC 00001002 000011A88A82
p 2F63
e jalrC 00001004 00000003E398
p 1234
p ABCD
e fullA 00001006 0000ABCD1234
p 5265
e lwSp 0000100A 000000B0BF96
p 6F47
e lhFp 0000100C 0000FFE8FE96
p 914C
e swSp 0000100E 000000519FB6
p A061
e shFp 00001010 000000183EB6
p D66A
e lwMapped 00001012 000000B24496
p EB5F
e shMapped 00001014 0000FFBA74B6
p 3040
e nopCode 00001016 00000000009C
p 3E7F
e nopCode2 00001018 00000000009C
p 0F80
p 5555
e fullB 0000101A 000055550F80
p 0365
e movAfterFull 0000101E 00008B80E582
